//--- hw/QuplsPkg.sv
/*
	Shared types and constants for the instruction decode stage. Compile it
	before every decode module. The modules pull it in with a wildcard import.
*/

package QuplsPkg;

// ====================
// Constants
// ====================

// Bit 22 of the instruction word selects immediate-as-operand-A
localparam int SwapBit = 22;

// The immediate field is nine bits wide and sits at the top of the word
localparam int ImmFieldWidth = 9;

// The decoded bundle carries a 64-bit sign-extended immediate
localparam int BusImmWidth = 64;

// ====================
// Instruction format
// ====================

// Opcode values in use. Any value not listed here decodes as illegal
typedef enum logic [6:0] {
	OP_ADDI   = 7'd4,
	OP_SUBFI  = 7'd5,
	OP_CMPI   = 7'd6,
	OP_MULI   = 7'd7,
	OP_DIVI   = 7'd8,
	OP_ANDI   = 7'd9,
	OP_ORI    = 7'd10,
	OP_EORI   = 7'd11,
	OP_JSR    = 7'd12,
	OP_ADD    = 7'd16,
	OP_SUB    = 7'd17,
	OP_LDx    = 7'd32,
	OP_LDxU   = 7'd33,
	OP_FLDx   = 7'd34,
	OP_DFLDx  = 7'd35,
	OP_PLDx   = 7'd36,
	OP_CACHE  = 7'd39,
	OP_STx    = 7'd40,
	OP_FSTx   = 7'd41,
	OP_DFSTx  = 7'd42,
	OP_PSTx   = 7'd43,
	OP_NOP    = 7'd127
} opcode_t;

// Field order runs from the top of the word down to the opcode at bit 0
typedef struct packed {
	logic [ImmFieldWidth-1:0] immediate;
	logic swapBit;
	logic [2:0] func;
	logic [5:0] Rs1;
	logic [5:0] Rd;
	opcode_t opcode;
} instruction_t;

// ====================
// Decoded bundle
// ====================

// Functional unit that will execute the instruction
typedef enum logic [2:0] {
	UNIT_ALU     = 3'd0,
	UNIT_MUL     = 3'd1,
	UNIT_DIV     = 3'd2,
	UNIT_LOAD    = 3'd3,
	UNIT_STORE   = 3'd4,
	UNIT_BRANCH  = 3'd5,
	UNIT_NONE    = 3'd6,
	UNIT_ILLEGAL = 3'd7
} unit_t;

// What the decoder hands on to issue
typedef struct packed {
	unit_t unit;
	logic [5:0] Rd;
	logic [5:0] Rs1;
	logic [2:0] func;
	logic hasImm;
	logic aIsImm;
	logic bIsImm;
	logic [BusImmWidth-1:0] imm;
} decodeBus_t;

// The single list of opcodes that carry an immediate operand
// New immediate-form opcodes are added here and both the swap and
// immediate decoders pick them up
function automatic logic fnIsImmForm(input opcode_t op);
	case (op)
	OP_ADDI, OP_CMPI, OP_MULI, OP_DIVI, OP_SUBFI,
	OP_ANDI, OP_ORI, OP_EORI, OP_JSR:
		fnIsImmForm = 1'b1;
	OP_LDx, OP_LDxU, OP_FLDx, OP_DFLDx, OP_PLDx, OP_CACHE:
		fnIsImmForm = 1'b1;
	OP_STx, OP_FSTx, OP_DFSTx, OP_PSTx:
		fnIsImmForm = 1'b1;
	default:
		fnIsImmForm = 1'b0;
	endcase
endfunction

endpackage

//--- hw/QuplsDecodeSwap.sv
/*
	Operand swap decoder. Reports whether the immediate moves into the first
	operand slot. Purely combinational and used inside the instruction decoder.
*/

`timescale 1ns/100ps

module QuplsDecodeSwap
(
	input QuplsPkg::instruction_t instr,
	output logic swap
);
import QuplsPkg::*;

// The swap bit only means something on immediate-form opcodes
// Register-register forms such as ADD and SUB reuse bit 22 for other
// purposes so it is ignored there
function automatic logic fnSwap(input instruction_t ins);
	if (fnIsImmForm(ins.opcode))
		fnSwap = ins[SwapBit];
	else
		fnSwap = 1'b0;
endfunction

// Loads and stores are part of the list too, so an address can be
// formed as imm + Rs1 with either operand order
assign swap = fnSwap(instr);

endmodule

//--- hw/QuplsDecodeImm.sv
/*
	Immediate decoder. Sign-extends the nine-bit immediate to the datapath
	width and flags whether the opcode carries one. Combinational only.
*/

`timescale 1ns/100ps

module QuplsDecodeImm #(
	parameter int DataWidth = 64
)
(
	input QuplsPkg::instruction_t instr,
	output logic [DataWidth-1:0] imm,
	output logic hasImm
);
import QuplsPkg::*;

// Number of copies of the sign bit needed above the raw field
localparam int ExtBits = DataWidth - ImmFieldWidth;

logic immSign;
logic [DataWidth-1:0] immExt;

// Same opcode list the swap decoder uses
assign hasImm = fnIsImmForm(instr.opcode);

// The top bit of the field is the sign
assign immSign = instr.immediate[ImmFieldWidth-1];

// Replicate the sign across the upper bits
assign immExt = {{ExtBits{immSign}}, instr.immediate};

// Register-register and illegal forms get a clean zero so that downstream
// stages never see leftover field bits
always_comb
begin
	if (hasImm)
		imm = immExt;
	else
		imm = '0;
end

endmodule

//--- hw/QuplsDecoder.sv
/*
	Instruction decoder. Classifies the opcode into a functional unit, copies
	the register fields and builds the decoded bundle. Zero-cycle logic that
	sits between the input and output holding slots.
*/

`timescale 1ns/100ps

module QuplsDecoder #(
	parameter int DataWidth = 64
)
(
	input QuplsPkg::instruction_t instr,
	output QuplsPkg::decodeBus_t bus
);
import QuplsPkg::*;

logic swap;
logic hasImm;
logic [DataWidth-1:0] imm;
unit_t opUnit;

// ====================
// Sub-decoders
// ====================

// Operand order
QuplsDecodeSwap swapDec
(
	.instr(instr),
	.swap(swap)
);

// Immediate extraction at the full datapath width
QuplsDecodeImm #(
	.DataWidth(DataWidth)
) immDec
(
	.instr(instr),
	.imm(imm),
	.hasImm(hasImm)
);

// ====================
// Unit classification
// ====================

// CACHE goes to the load unit since it uses the same address path
function automatic unit_t fnUnit(input opcode_t op);
	case (op)
	OP_ADDI, OP_CMPI, OP_SUBFI, OP_ANDI, OP_ORI, OP_EORI, OP_ADD, OP_SUB:
		fnUnit = UNIT_ALU;
	OP_MULI:
		fnUnit = UNIT_MUL;
	OP_DIVI:
		fnUnit = UNIT_DIV;
	OP_LDx, OP_LDxU, OP_FLDx, OP_DFLDx, OP_PLDx, OP_CACHE:
		fnUnit = UNIT_LOAD;
	OP_STx, OP_FSTx, OP_DFSTx, OP_PSTx:
		fnUnit = UNIT_STORE;
	OP_JSR:
		fnUnit = UNIT_BRANCH;
	OP_NOP:
		fnUnit = UNIT_NONE;
	default:
		fnUnit = UNIT_ILLEGAL;
	endcase
endfunction

assign opUnit = fnUnit(instr.opcode);

// ====================
// Bundle assembly
// ====================

// Start from all zeros so an illegal opcode carries nothing but its unit
always_comb
begin
	bus = '0;
	bus.unit = opUnit;
	if (opUnit != UNIT_ILLEGAL)
	begin
		bus.Rd = instr.Rd;
		bus.Rs1 = instr.Rs1;
		bus.func = instr.func;
		bus.hasImm = hasImm;
		// Exactly one operand takes the immediate when there is one
		bus.aIsImm = hasImm & swap;
		bus.bIsImm = hasImm & ~swap;
		// Bundle field is fixed at the package width
		bus.imm = BusImmWidth'(imm);
	end
end

endmodule

//--- hw/QuplsHoldSlot.sv
/*
	One-entry holding register with a four-phase req/ack handshake on each
	side. The payload type is a parameter so the same slot carries raw
	instructions and decoded bundles.
*/

`timescale 1ns/100ps

module QuplsHoldSlot #(
	parameter type payload_t = logic
)
(
	input logic clk,
	input logic rst,
	input logic upReq,
	input payload_t upData,
	output logic upAck,
	output logic dnReq,
	output payload_t dnData,
	input logic dnAck
);

// Set while a payload is held and not yet taken downstream
logic full;

// The stored payload
payload_t data;

// Capture condition
logic take;

// Accept only into an empty slot, on a fresh request, and once the
// previous downstream transfer has fully closed with ack low again
// A full slot or a lingering downstream ack stalls the upstream side
assign take = ~full & upReq & ~upAck & ~dnAck;

// ====================
// Control
// ====================

always_ff @(posedge clk)
begin
	if (rst)
	begin
		full <= 1'b0;
		upAck <= 1'b0;
		dnReq <= 1'b0;
	end
	else
	begin
		// Upstream side. Ack stays high until the sender drops req
		if (take)
		begin
			full <= 1'b1;
			upAck <= 1'b1;
		end
		else if (upAck & ~upReq)
			upAck <= 1'b0;

		// Downstream side. Req goes up one edge after the slot fills
		// and only when the receiver has released its ack
		if (full & ~dnReq & ~dnAck)
			dnReq <= 1'b1;
		else if (dnReq & dnAck)
		begin
			// Receiver has the data, so the slot frees up
			dnReq <= 1'b0;
			full <= 1'b0;
		end
	end
end

// ====================
// Payload
// ====================

// Loaded only on capture, so the output holds steady until release
always_ff @(posedge clk)
begin
	if (take)
		data <= upData;
end

assign dnData = data;

endmodule

//--- hw/QuplsDecodeTop.sv
/*
	Decode stage top level. An input slot holds the raw instruction, the
	decoder works on it combinationally and an output slot offers the result
	downstream. Both outer ports use a four-phase req/ack handshake.
*/

`timescale 1ns/100ps

module QuplsDecodeTop #(
	parameter int DataWidth = QuplsPkg::BusImmWidth
)
(
	input logic clk,
	input logic rst,
	input logic inReq,
	input QuplsPkg::instruction_t inInstr,
	output logic inAck,
	output logic outReq,
	output QuplsPkg::decodeBus_t outBus,
	input logic outAck
);
import QuplsPkg::*;

// Handshake and data between the input slot and the output slot
logic heldReq;
logic heldAck;
instruction_t heldInstr;
decodeBus_t decodedBus;

// Raw instruction buffer
QuplsHoldSlot #(
	.payload_t(instruction_t)
) inSlot
(
	.clk(clk),
	.rst(rst),
	.upReq(inReq),
	.upData(inInstr),
	.upAck(inAck),
	.dnReq(heldReq),
	.dnData(heldInstr),
	.dnAck(heldAck)
);

// The held instruction is stable while heldReq is up, so the decoded
// bundle is stable too when the output slot captures it
QuplsDecoder #(
	.DataWidth(DataWidth)
) decoder
(
	.instr(heldInstr),
	.bus(decodedBus)
);

// Decoded bundle buffer
QuplsHoldSlot #(
	.payload_t(decodeBus_t)
) outSlot
(
	.clk(clk),
	.rst(rst),
	.upReq(heldReq),
	.upData(decodedBus),
	.upAck(heldAck),
	.dnReq(outReq),
	.dnData(outBus),
	.dnAck(outAck)
);

endmodule

//--- verification/QuplsDecodeTb.sv
/*
	Directed testbench for the decode stage. Sends instructions through the
	upstream four-phase port, takes bundles from the downstream port and
	compares them in order against a reference decode of the opcode rules.
*/

`timescale 1ns/100ps

module QuplsDecodeTb;
import QuplsPkg::*;

// ====================
// Run limits
// ====================

localparam int ResetCycles = 16;
localparam int PollLimit = 50;
localparam int DirectedCount = 49;
localparam int RandomCount = 200;
localparam int MaxAckDelay = 3;
// One instruction needs at most about eight cycles through both slots
localparam int CyclesPerInstr = 8;
localparam int WatchdogCycles = ResetCycles + (DirectedCount + RandomCount) * CyclesPerInstr;

logic clk;
logic rst;
logic inReq;
instruction_t inInstr;
logic inAck;
logic outReq;
decodeBus_t outBus;
logic outAck;

int errors;
int checks;
int seed;
// Bundles still owed by the DUT, oldest first
decodeBus_t expQ[$];
decodeBus_t lastBus;

// Opcodes that carry an immediate, then the full legal set
opcode_t immOps [19] = '{OP_ADDI, OP_CMPI, OP_MULI, OP_DIVI, OP_SUBFI, OP_ANDI,
	OP_ORI, OP_EORI, OP_JSR, OP_LDx, OP_LDxU, OP_FLDx, OP_DFLDx, OP_PLDx,
	OP_CACHE, OP_STx, OP_FSTx, OP_DFSTx, OP_PSTx};
opcode_t allOps [22] = '{OP_ADDI, OP_CMPI, OP_MULI, OP_DIVI, OP_SUBFI, OP_ANDI,
	OP_ORI, OP_EORI, OP_JSR, OP_LDx, OP_LDxU, OP_FLDx, OP_DFLDx, OP_PLDx,
	OP_CACHE, OP_STx, OP_FSTx, OP_DFSTx, OP_PSTx, OP_ADD, OP_SUB, OP_NOP};

QuplsDecodeTop #(
	.DataWidth(64)
) UUT
(
	.clk(clk),
	.rst(rst),
	.inReq(inReq),
	.inInstr(inInstr),
	.inAck(inAck),
	.outReq(outReq),
	.outBus(outBus),
	.outAck(outAck)
);

initial
begin
	clk = 1'b0;
	forever #5 clk = ~clk;
end

// Ends a hung run
initial
begin
	repeat (WatchdogCycles) @(posedge clk);
	$display("Watchdog expired after %0d cycles, the tests did not finish", WatchdogCycles);
	$display("Test FAILED");
	$finish;
end

// ====================
// Reference model
// ====================

// Expected bundle worked out from the opcode table
function automatic decodeBus_t refDecode(input instruction_t ins);
	decodeBus_t b;
	unit_t u;
	logic immForm;
	case (ins.opcode)
	OP_ADDI, OP_CMPI, OP_SUBFI, OP_ANDI, OP_ORI, OP_EORI, OP_ADD, OP_SUB: u = UNIT_ALU;
	OP_MULI: u = UNIT_MUL;
	OP_DIVI: u = UNIT_DIV;
	OP_LDx, OP_LDxU, OP_FLDx, OP_DFLDx, OP_PLDx, OP_CACHE: u = UNIT_LOAD;
	OP_STx, OP_FSTx, OP_DFSTx, OP_PSTx: u = UNIT_STORE;
	OP_JSR: u = UNIT_BRANCH;
	OP_NOP: u = UNIT_NONE;
	default: u = UNIT_ILLEGAL;
	endcase
	// Every real unit takes an immediate except register-register ALU ops and NOP
	immForm = (u != UNIT_ILLEGAL) && (u != UNIT_NONE) && (ins.opcode != OP_ADD) &&
		(ins.opcode != OP_SUB);
	b = '0;
	b.unit = u;
	if (u != UNIT_ILLEGAL)
	begin
		b.Rd = ins.Rd;
		b.Rs1 = ins.Rs1;
		b.func = ins.func;
		b.hasImm = immForm;
		b.aIsImm = immForm & ins.swapBit;
		b.bIsImm = immForm & ~ins.swapBit;
		if (immForm)
			b.imm = {{55{ins.immediate[8]}}, ins.immediate};
	end
	return b;
endfunction

function automatic instruction_t buildInstr(input opcode_t op, input logic [8:0] imm,
	input logic sw, input logic [2:0] fn, input logic [5:0] rs1, input logic [5:0] rd);
	instruction_t ins;
	ins.immediate = imm;
	ins.swapBit = sw;
	ins.func = fn;
	ins.Rs1 = rs1;
	ins.Rd = rd;
	ins.opcode = op;
	return ins;
endfunction

// Mostly legal opcodes with an occasional raw seven-bit value
task automatic makeRandomInstr(output instruction_t ins);
	int pick;
	ins = instruction_t'($random(seed));
	pick = $unsigned($random(seed)) % 24;
	if (pick < 22)
		ins.opcode = allOps[pick];
	else
		ins.opcode = opcode_t'(7'($random(seed)));
endtask

// ====================
// Handshake tasks
// ====================

// All polling happens 1 ns after a rising edge
task automatic waitInAck(input logic level);
	int n;
	n = 0;
	while (inAck !== level && n < PollLimit)
	begin
		@(posedge clk);
		#1;
		n++;
	end
	if (inAck !== level)
	begin
		errors++;
		$display("Timed out at %0t waiting for inAck to become %b", $time, level);
	end
endtask

task automatic waitOutReq(input logic level);
	int n;
	n = 0;
	while (outReq !== level && n < PollLimit)
	begin
		@(posedge clk);
		#1;
		n++;
	end
	if (outReq !== level)
	begin
		errors++;
		$display("Timed out at %0t waiting for outReq to become %b", $time, level);
	end
endtask

// A new request only goes up once the previous ack is low
task automatic offerInstr(input instruction_t ins);
	waitInAck(1'b0);
	expQ.push_back(refDecode(ins));
	inInstr = ins;
	inReq = 1'b1;
endtask

task automatic finishSend();
	waitInAck(1'b1);
	inReq = 1'b0;
	waitInAck(1'b0);
endtask

task automatic sendInstr(input instruction_t ins);
	offerInstr(ins);
	finishSend();
endtask

task automatic takeBus(input int ackDelay);
	decodeBus_t expBus;
	waitOutReq(1'b1);
	if (outReq === 1'b1)
	begin
		checks++;
		if (expQ.size() == 0)
		begin
			errors++;
			$display("Output offered a bundle at %0t with none expected", $time);
		end
		else
		begin
			expBus = expQ.pop_front();
			if (outBus !== expBus)
			begin
				errors++;
				$display("FAIL %0t: outBus %h, expected %h", $time, outBus, expBus);
			end
		end
		lastBus = outBus;
		repeat (ackDelay)
		begin
			@(posedge clk);
			#1;
		end
		outAck = 1'b1;
		waitOutReq(1'b0);
		outAck = 1'b0;
	end
endtask

// ====================
// Tests
// ====================

task automatic testFirstAddi();
	instruction_t ins;
	int cycles;
	checks++;
	if (inAck !== 1'b0 || outReq !== 1'b0)
	begin
		errors++;
		$display("FAIL %0t: inAck or outReq not low after reset", $time);
	end
	ins = buildInstr(OP_ADDI, 9'h1F0, 1'b0, 3'd2, 6'd5, 6'd9);
	offerInstr(ins);
	cycles = 0;
	fork
		finishSend();
		while (outReq !== 1'b1 && cycles < PollLimit)
		begin
			@(posedge clk);
			#1;
			cycles++;
		end
	join
	checks++;
	if (cycles > 6)
	begin
		errors++;
		$display("FAIL %0t: outReq took %0d cycles, limit 6", $time, cycles);
	end
	takeBus(0);
	checks++;
	if (lastBus.unit !== UNIT_ALU || lastBus.bIsImm !== 1'b1 || lastBus.aIsImm !== 1'b0 ||
		lastBus.imm !== 64'hFFFF_FFFF_FFFF_FFF0)
	begin
		errors++;
		$display("FAIL %0t: ADDI decoded as %h", $time, lastBus);
	end
endtask

// Bit 22 moves the immediate to operand A only on immediate forms
task automatic testSwapRule();
	instruction_t ins;
	opcode_t regOps [3];
	regOps = '{OP_ADD, OP_SUB, OP_NOP};
	foreach (immOps[i])
	begin
		ins = buildInstr(immOps[i], 9'(i * 13), 1'b1, 3'(i), 6'(i + 1), 6'(40 - i));
		sendInstr(ins);
		takeBus(0);
		checks++;
		if (lastBus.aIsImm !== 1'b1 || lastBus.bIsImm !== 1'b0)
		begin
			errors++;
			$display("FAIL %0t: swap not applied for %s", $time, immOps[i].name());
		end
	end
	foreach (regOps[i])
	begin
		ins = buildInstr(regOps[i], 9'h155, 1'b1, 3'd6, 6'd17, 6'd18);
		sendInstr(ins);
		takeBus(0);
		checks++;
		if (lastBus.hasImm !== 1'b0 || lastBus.aIsImm !== 1'b0 || lastBus.bIsImm !== 1'b0)
		begin
			errors++;
			$display("FAIL %0t: %s picked up an immediate", $time, regOps[i].name());
		end
	end
endtask

task automatic testUnitMap();
	instruction_t ins;
	decodeBus_t zeroBus;
	logic [6:0] badCode;
	foreach (allOps[i])
	begin
		ins = buildInstr(allOps[i], 9'(i * 29), 1'(i), 3'(i + 3), 6'(2 * i), 6'(63 - i));
		sendInstr(ins);
		takeBus(0);
	end
	// 100 is not an assigned opcode
	badCode = 7'd100;
	ins = buildInstr(OP_NOP, 9'h1FF, 1'b1, 3'd7, 6'd63, 6'd63);
	ins.opcode = opcode_t'(badCode);
	sendInstr(ins);
	takeBus(0);
	zeroBus = '0;
	zeroBus.unit = UNIT_ILLEGAL;
	checks++;
	if (lastBus !== zeroBus)
	begin
		errors++;
		$display("FAIL %0t: illegal opcode gave %h", $time, lastBus);
	end
endtask

// With outAck held low both slots fill and the third offer must stall
task automatic testBackPressure();
	instruction_t trio [3];
	logic sawAck;
	trio[0] = buildInstr(OP_MULI, 9'h0A5, 1'b0, 3'd1, 6'd11, 6'd12);
	trio[1] = buildInstr(OP_LDx, 9'h17F, 1'b1, 3'd3, 6'd21, 6'd22);
	trio[2] = buildInstr(OP_STx, 9'h003, 1'b0, 3'd5, 6'd31, 6'd32);
	sendInstr(trio[0]);
	sendInstr(trio[1]);
	offerInstr(trio[2]);
	sawAck = 1'b0;
	repeat (8)
	begin
		@(posedge clk);
		#1;
		if (inAck === 1'b1)
			sawAck = 1'b1;
	end
	checks++;
	if (sawAck || outReq !== 1'b1)
	begin
		errors++;
		$display("FAIL %0t: stall not held, inAck seen %b, outReq %b", $time, sawAck, outReq);
	end
	fork
		finishSend();
		repeat (3) takeBus(0);
	join
endtask

task automatic testRandomStream();
	instruction_t stream [RandomCount];
	int delays [RandomCount];
	foreach (stream[i])
	begin
		makeRandomInstr(stream[i]);
		delays[i] = $unsigned($random(seed)) % (MaxAckDelay + 1);
	end
	fork
		foreach (stream[i]) sendInstr(stream[i]);
		foreach (delays[i]) takeBus(delays[i]);
	join
endtask

// ====================
// Main sequence
// ====================

initial
begin
	errors = 0;
	checks = 0;
	seed = 9;
	rst = 1'b1;
	inReq = 1'b0;
	inInstr = '0;
	outAck = 1'b0;
	repeat (ResetCycles) @(posedge clk);
	#1;
	rst = 1'b0;
	testFirstAddi();
	testSwapRule();
	testUnitMap();
	testBackPressure();
	testRandomStream();
	checks++;
	if (expQ.size() != 0)
	begin
		errors++;
		$display("%0d expected bundles never came out of the DUT", expQ.size());
	end
	$display("Checks: %0d  Errors: %0d", checks, errors);
	if (errors == 0)
		$display("Test OK");
	else
		$display("Test FAILED");
	$finish;
end

endmodule

//--- QuplsDecodeTop.f
hw/QuplsPkg.sv
hw/QuplsDecodeSwap.sv
hw/QuplsDecodeImm.sv
hw/QuplsDecoder.sv
hw/QuplsHoldSlot.sv
hw/QuplsDecodeTop.sv
verification/QuplsDecodeTb.sv

//--- runSim.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module QuplsDecodeTb -f QuplsDecodeTop.f \
	-o QuplsDecodeSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

simOut=$(./obj_dir/QuplsDecodeSim)
simStatus=$?
printf '%s\n' "$simOut"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

# The run passes only if the pass line shows up in the output
if printf '%s\n' "$simOut" | grep -qx "Test OK"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1
